/* filelist.f */
hdl/gat_coef_pkg.sv
hdl/wh_mem_if.sv
hdl/wh_ram.sv
hdl/wh_mem_arbiter.sv
hdl/wh_loader.sv
hdl/coef_fetch.sv
hdl/dmvm.sv
hdl/gat_coef_top.sv
verification/gat_coef_asserts.sv
verification/tb_gat_coef.sv

/* hdl/coef_fetch.sv */
// ==================================================
// Coefficient fetch engine
// Reads a run of WH rows, stalls on a full FIFO
// ==================================================

module coef_fetch (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    run_i,
  input  gat_coef_pkg::wh_addr_t  run_base_i,
  input  gat_coef_pkg::cnt_t      run_len_i,
  input  logic                    coef_full_i,
  output logic                    busy_o,
  output logic                    row_vld_o,
  wh_mem_if.requester             bus
);

  gat_coef_pkg::fetch_state_t  state_q;
  gat_coef_pkg::wh_addr_t      addr_q;
  gat_coef_pkg::cnt_t          remain_q;
  logic                        row_vld_q;

  // No request at all while the FIFO reports full
  assign bus.req   = (state_q == gat_coef_pkg::READ) && !coef_full_i;
  assign bus.we    = 1'b0;
  assign bus.addr  = addr_q;
  assign bus.wdata = '0;

  assign busy_o    = (state_q != gat_coef_pkg::IDLE);
  assign row_vld_o = row_vld_q;

  // ==================================================
  // Run FSM
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= gat_coef_pkg::IDLE;
      addr_q   <= '0;
      remain_q <= '0;
    end else begin
      case (state_q)
        gat_coef_pkg::IDLE: begin
          if (run_i && (run_len_i != '0)) begin
            addr_q   <= run_base_i;
            remain_q <= run_len_i;
            state_q  <= gat_coef_pkg::READ;
          end
        end
        gat_coef_pkg::READ: begin
          if (coef_full_i) begin
            state_q <= gat_coef_pkg::STALL;
          end else if (bus.gnt) begin
            addr_q   <= addr_q + 1'b1;
            remain_q <= remain_q - 1'b1;
            if (remain_q == 6'd1) begin
              state_q <= gat_coef_pkg::IDLE;
            end
          end
        end
        gat_coef_pkg::STALL: begin
          if (!coef_full_i) begin
            state_q <= gat_coef_pkg::READ;
          end
        end
        default: state_q <= gat_coef_pkg::IDLE;
      endcase
    end
  end

  // Row strobe lines up with read data from the memory
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_vld_q <= 1'b0;
    end else begin
      row_vld_q <= bus.gnt;
    end
  end

endmodule

/* hdl/dmvm.sv */
// ==================================================
// Dual dot-product attention pipeline
// Source and neighbour sums, ReLU coefficient out
// ==================================================

module dmvm (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   a_wr_i,
  input  logic [gat_coef_pkg::A_IDX_W-1:0]       a_idx_i,
  input  gat_coef_pkg::attn_w_t                  a_data_i,
  input  logic                                   row_vld_i,
  input  gat_coef_pkg::wh_word_t                 row_i,
  output gat_coef_pkg::coef_t                    coef_o,
  output logic                                   coef_vld_o
);

  localparam int NF   = gat_coef_pkg::NUM_FEATURE;
  localparam int NS   = gat_coef_pkg::NUM_STAGES;
  localparam int LAT  = gat_coef_pkg::DMVM_LATENCY;
  localparam int FW   = gat_coef_pkg::WH_DATA_W;
  localparam int WW   = gat_coef_pkg::WH_WORD_W;

  gat_coef_pkg::attn_w_t    a_q [2*NF];
  gat_coef_pkg::wh_word_t   row_q;
  gat_coef_pkg::wh_feat_t   feat [NF];

  // Index 0 is the source half, index 1 the neighbour half
  gat_coef_pkg::dmvm_sum_t  prod_q [2][NF];
  gat_coef_pkg::dmvm_sum_t  lvl1_q [2][NF/2];
  gat_coef_pkg::dmvm_sum_t  sum_q  [2];

  gat_coef_pkg::dmvm_sum_t  src_hold_q;
  gat_coef_pkg::dmvm_sum_t  src_cur;
  logic signed [gat_coef_pkg::DMVM_W:0] total;
  logic signed [gat_coef_pkg::DMVM_W:0] total_sh;
  gat_coef_pkg::coef_t      coef_trunc;
  gat_coef_pkg::coef_t      coef_q;

  logic [LAT-1:0]           vld_sr;
  logic [NS-1:0]            flag_sr;
  logic                     src_upd;

  // ==================================================
  // Attention weight bank
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 2*NF; i++) begin
        a_q[i] <= '0;
      end
    end else if (a_wr_i) begin
      a_q[a_idx_i] <= a_data_i;
    end
  end

  // Capture the row as it leaves the memory
  always_ff @(posedge clk) begin
    if (row_vld_i) begin
      row_q <= row_i;
    end
  end

  // Feature 0 sits in the top bits of the word
  always_comb begin
    for (int k = 0; k < NF; k++) begin
      feat[k] = row_q[WW-1-k*FW -: FW];
    end
  end

  // ==================================================
  // Multiply and adder tree
  // ==================================================
  always_ff @(posedge clk) begin
    for (int h = 0; h < 2; h++) begin
      for (int k = 0; k < NF; k++) begin
        prod_q[h][k] <= a_q[h*NF+k] * feat[k];
      end
      for (int k = 0; k < NF/2; k++) begin
        lvl1_q[h][k] <= prod_q[h][2*k] + prod_q[h][2*k+1];
      end
      sum_q[h] <= lvl1_q[h][0] + lvl1_q[h][1];
    end
  end

  // Valid and source flag travel beside the data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_sr  <= '0;
      flag_sr <= '0;
    end else begin
      vld_sr  <= {vld_sr[LAT-2:0], row_vld_i};
      flag_sr <= {flag_sr[NS-2:0], row_q[0]};
    end
  end

  // ==================================================
  // Source hold and coefficient
  // ==================================================
  assign src_upd = flag_sr[NS-1] && vld_sr[NS];
  // A source row uses its own fresh sum
  assign src_cur = src_upd ? sum_q[0] : src_hold_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      src_hold_q <= '0;
    end else begin
      src_hold_q <= src_cur;
    end
  end

  assign total      = src_cur + sum_q[1];
  assign total_sh   = total >>> gat_coef_pkg::COEF_SHIFT;
  assign coef_trunc = total_sh[gat_coef_pkg::DATA_W-1:0];

  // ReLU on the truncated value
  always_ff @(posedge clk) begin
    coef_q <= coef_trunc[gat_coef_pkg::DATA_W-1] ? '0 : coef_trunc;
  end

  assign coef_o     = coef_q;
  assign coef_vld_o = vld_sr[LAT-1];

endmodule

/* hdl/gat_coef_pkg.sv */
// ==================================================
// Graph-attention coefficient package
// Widths, depths, latencies and shared types
// ==================================================

package gat_coef_pkg;

  localparam int NUM_FEATURE  = 4;
  // Multiply stage plus two adder tree levels
  localparam int NUM_STAGES   = 3;
  localparam int DATA_W       = 8;
  localparam int WH_DATA_W    = 12;
  localparam int DMVM_W       = 22;
  localparam int COEF_SHIFT   = 10;
  localparam int WH_DEPTH     = 32;
  localparam int WH_ADDR_W    = 5;
  // Four features then the source flag in bit 0
  localparam int WH_WORD_W    = 49;
  // Weights 0..3 source half, 4..7 neighbour half
  localparam int A_IDX_W      = 3;
  // Input register, three tree stages, output register
  localparam int DMVM_LATENCY = 5;

  typedef logic        [WH_ADDR_W-1:0] wh_addr_t;
  typedef logic        [WH_WORD_W-1:0] wh_word_t;
  typedef logic signed [WH_DATA_W-1:0] wh_feat_t;
  typedef logic signed [DATA_W-1:0]    attn_w_t;
  typedef logic signed [DMVM_W-1:0]    dmvm_sum_t;
  typedef logic        [DATA_W-1:0]    coef_t;
  typedef logic        [5:0]           cnt_t;

  typedef enum logic [1:0] {IDLE, READ, STALL} fetch_state_t;

endpackage

/* hdl/gat_coef_top.sv */
// ==================================================
// Graph-attention coefficient subsystem
// Loader, fetch, arbiter, WH memory and pipeline
// ==================================================

module gat_coef_top (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 wh_wr_i,
  input  gat_coef_pkg::wh_addr_t               wh_addr_i,
  input  gat_coef_pkg::wh_word_t               wh_data_i,
  output logic                                 wh_busy_o,
  input  logic                                 a_wr_i,
  input  logic [gat_coef_pkg::A_IDX_W-1:0]     a_idx_i,
  input  gat_coef_pkg::attn_w_t                a_data_i,
  input  logic                                 run_i,
  input  gat_coef_pkg::wh_addr_t               run_base_i,
  input  gat_coef_pkg::cnt_t                   run_len_i,
  output logic                                 run_busy_o,
  input  logic                                 coef_full_i,
  output gat_coef_pkg::coef_t                  coef_o,
  output logic                                 coef_vld_o
);

  wh_mem_if ld_bus ();
  wh_mem_if rd_bus ();

  logic                    ram_en;
  logic                    ram_we;
  gat_coef_pkg::wh_addr_t  ram_addr;
  gat_coef_pkg::wh_word_t  ram_wdata;
  gat_coef_pkg::wh_word_t  ram_rdata;
  logic                    row_vld;

  // ==================================================
  // Memory peers
  // ==================================================
  wh_loader u_loader (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_i   (wh_wr_i),
    .addr_i (wh_addr_i),
    .data_i (wh_data_i),
    .busy_o (wh_busy_o),
    .bus    (ld_bus.requester)
  );

  coef_fetch u_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .run_i       (run_i),
    .run_base_i  (run_base_i),
    .run_len_i   (run_len_i),
    .coef_full_i (coef_full_i),
    .busy_o      (run_busy_o),
    .row_vld_o   (row_vld),
    .bus         (rd_bus.requester)
  );

  wh_mem_arbiter u_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .ld_bus      (ld_bus.arbiter),
    .rd_bus      (rd_bus.arbiter),
    .ram_en_o    (ram_en),
    .ram_we_o    (ram_we),
    .ram_addr_o  (ram_addr),
    .ram_wdata_o (ram_wdata),
    .ram_rdata_i (ram_rdata)
  );

  wh_ram u_ram (
    .clk     (clk),
    .en_i    (ram_en),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

  // ==================================================
  // Coefficient pipeline
  // ==================================================
  dmvm u_dmvm (
    .clk        (clk),
    .rst_n      (rst_n),
    .a_wr_i     (a_wr_i),
    .a_idx_i    (a_idx_i),
    .a_data_i   (a_data_i),
    .row_vld_i  (row_vld),
    .row_i      (rd_bus.rdata),
    .coef_o     (coef_o),
    .coef_vld_o (coef_vld_o)
  );

endmodule

/* hdl/wh_loader.sv */
// ==================================================
// Host WH row loader
// Holds one write until the arbiter grants it
// ==================================================

module wh_loader (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    wr_i,
  input  gat_coef_pkg::wh_addr_t  addr_i,
  input  gat_coef_pkg::wh_word_t  data_i,
  output logic                    busy_o,
  wh_mem_if.requester             bus
);

  logic                    pend_q;
  gat_coef_pkg::wh_addr_t  pend_addr_q;
  gat_coef_pkg::wh_word_t  pend_data_q;

  // Request straight from the host strobe, then from the pending copy
  assign bus.req   = wr_i || pend_q;
  assign bus.we    = 1'b1;
  assign bus.addr  = pend_q ? pend_addr_q : addr_i;
  assign bus.wdata = pend_q ? pend_data_q : data_i;

  assign busy_o = pend_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= 1'b0;
    end else begin
      pend_q <= bus.req && !bus.gnt;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_i) begin
      pend_addr_q <= addr_i;
      pend_data_q <= data_i;
    end
  end

endmodule

/* hdl/wh_mem_arbiter.sv */
// ==================================================
// WH memory arbiter
// Round-robin between host loader and fetch engine
// ==================================================

module wh_mem_arbiter (
  input  logic                    clk,
  input  logic                    rst_n,
  wh_mem_if.arbiter               ld_bus,
  wh_mem_if.arbiter               rd_bus,
  output logic                    ram_en_o,
  output logic                    ram_we_o,
  output gat_coef_pkg::wh_addr_t  ram_addr_o,
  output gat_coef_pkg::wh_word_t  ram_wdata_o,
  input  gat_coef_pkg::wh_word_t  ram_rdata_i
);

  // High when the fetch engine was served last
  logic last_rd_q;
  logic ld_gnt;
  logic rd_gnt;

  // ==================================================
  // Grant decision
  // ==================================================
  // On a conflict the peer not served last wins
  assign ld_gnt = ld_bus.req && (!rd_bus.req || last_rd_q);
  assign rd_gnt = rd_bus.req && (!ld_bus.req || !last_rd_q);

  assign ld_bus.gnt = ld_gnt;
  assign rd_bus.gnt = rd_gnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_rd_q <= 1'b0;
    end else if (ld_gnt) begin
      last_rd_q <= 1'b0;
    end else if (rd_gnt) begin
      last_rd_q <= 1'b1;
    end
  end

  // ==================================================
  // Memory port mux
  // ==================================================
  assign ram_en_o    = ld_gnt || rd_gnt;
  assign ram_we_o    = ld_gnt ? ld_bus.we    : (rd_gnt && rd_bus.we);
  assign ram_addr_o  = ld_gnt ? ld_bus.addr  : rd_bus.addr;
  assign ram_wdata_o = ld_gnt ? ld_bus.wdata : rd_bus.wdata;

  // Read data is shared, each peer knows when it asked
  assign ld_bus.rdata = ram_rdata_i;
  assign rd_bus.rdata = ram_rdata_i;

endmodule

/* hdl/wh_mem_if.sv */
// ==================================================
// WH memory requester port
// One peer's access path through the arbiter
// ==================================================

interface wh_mem_if;

  logic                    req;
  logic                    we;
  gat_coef_pkg::wh_addr_t  addr;
  gat_coef_pkg::wh_word_t  wdata;
  logic                    gnt;
  gat_coef_pkg::wh_word_t  rdata;

  modport requester (
    output req, we, addr, wdata,
    input  gnt, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output gnt, rdata
  );

endinterface

/* hdl/wh_ram.sv */
// ==================================================
// WH row memory
// Single port, registered read, one cycle latency
// ==================================================

module wh_ram (
  input  logic                    clk,
  input  logic                    en_i,
  input  logic                    we_i,
  input  gat_coef_pkg::wh_addr_t  addr_i,
  input  gat_coef_pkg::wh_word_t  wdata_i,
  output gat_coef_pkg::wh_word_t  rdata_o
);

  gat_coef_pkg::wh_word_t mem [gat_coef_pkg::WH_DEPTH];

  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

/* verification/coef_golden.txt */
// Word: op nibble _ arg byte (index, address or run base) _ 13-digit value
// op 1 weight, 2 WH row, 3 run (value = length), 4 full pattern, 5 expected, 6 test end
1_00_0000000000010
1_01_0000000000008
1_02_0000000000004
1_03_0000000000002
1_04_0000000000002
1_05_00000000000FC
1_06_0000000000008
1_07_0000000000010
2_00_0200100080001
2_01_0000000200100
2_02_0000800001C00
2_03_0400000000200
3_00_0000000000004
5_00_0000000000005
5_00_0000000000009
5_00_0000000000000
5_00_000000000000A
6_00_0000000000000
2_08_0000000000801
2_09_0100000000000
2_0A_0400400000001
2_0B_0000000200100
3_08_0000000000004
5_00_0000000000012
5_00_0000000000002
5_00_000000000000B
5_00_0000000000010
6_00_0000000000000
3_08_0000000000004
2_14_0AAAAAAAAAAAA
2_15_1555555555555
2_16_0123456789ABC
2_17_1FFFFFFFFFFFF
5_00_0000000000012
5_00_0000000000002
5_00_000000000000B
5_00_0000000000010
6_00_0000000000000
3_00_0000000000004
4_00_0000000003333
5_00_0000000000005
5_00_0000000000009
5_00_0000000000000
5_00_000000000000A
6_00_0000000000000

/* verification/gat_coef_asserts.sv */
// ==================================================
// Coefficient subsystem assertions
// Arbiter grants, reset and back-pressure rules
// ==================================================

module gat_coef_asserts (
  input logic clk,
  input logic rst_n,
  input logic ld_gnt_i,
  input logic rd_gnt_i,
  input logic coef_full_i,
  input logic coef_vld_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // Failed assertion count
  int assert_errs = 0;

  // One peer on the memory port at a time
  grant_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(ld_gnt_i && rd_gnt_i))
    else begin
      assert_errs++;
      $error("Loader and fetch engine granted in the same cycle");
    end

  vld_low_in_reset: assert property (@(posedge clk) !rst_n |-> !coef_vld_i)
    else begin
      assert_errs++;
      $error("coef_vld_o high while reset is asserted");
    end

  // Back-pressure stops new reads
  no_read_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    coef_full_i |-> !rd_gnt_i)
    else begin
      assert_errs++;
      $error("WH read granted while coef_full_i is high");
    end

endmodule

bind gat_coef_top gat_coef_asserts u_asserts (
  .clk         (clk),
  .rst_n       (rst_n),
  .ld_gnt_i    (ld_bus.gnt),
  .rd_gnt_i    (rd_bus.gnt),
  .coef_full_i (coef_full_i),
  .coef_vld_i  (coef_vld_o)
);

/* verification/tb_gat_coef.sv */
// ==================================================
// Graph-attention coefficient testbench
// Golden-file stimulus, coefficient checks, watchdog
// ==================================================

module tb_gat_coef;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_CMDS        = 128;
  localparam int RST_CYCLES      = 4;
  localparam int IDLE_CYCLES     = 8;
  localparam int CYCLES_PER_LINE = 20;

  // Opcodes in the top nibble of a golden word
  localparam logic [3:0] OP_WEIGHT = 4'h1;
  localparam logic [3:0] OP_ROW    = 4'h2;
  localparam logic [3:0] OP_RUN    = 4'h3;
  localparam logic [3:0] OP_FULL   = 4'h4;
  localparam logic [3:0] OP_EXPECT = 4'h5;
  localparam logic [3:0] OP_END    = 4'h6;

  logic                                 clk;
  logic                                 rst_n;
  logic                                 wh_wr_i;
  gat_coef_pkg::wh_addr_t               wh_addr_i;
  gat_coef_pkg::wh_word_t               wh_data_i;
  logic                                 wh_busy_o;
  logic                                 a_wr_i;
  logic [gat_coef_pkg::A_IDX_W-1:0]     a_idx_i;
  gat_coef_pkg::attn_w_t                a_data_i;
  logic                                 run_i;
  gat_coef_pkg::wh_addr_t               run_base_i;
  gat_coef_pkg::cnt_t                   run_len_i;
  logic                                 run_busy_o;
  logic                                 coef_full_i;
  gat_coef_pkg::coef_t                  coef_o;
  logic                                 coef_vld_o;

  logic [63:0]          cmd_mem [MAX_CMDS];
  int                   num_cmds;
  int                   seed;
  int                   err_cnt;
  int                   err_base;
  int                   test_idx;
  int                   pass_cnt;
  int                   fail_cnt;
  gat_coef_pkg::coef_t  got_q [$];
  gat_coef_pkg::coef_t  exp_q [$];

  gat_coef_top DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .wh_wr_i     (wh_wr_i),
    .wh_addr_i   (wh_addr_i),
    .wh_data_i   (wh_data_i),
    .wh_busy_o   (wh_busy_o),
    .a_wr_i      (a_wr_i),
    .a_idx_i     (a_idx_i),
    .a_data_i    (a_data_i),
    .run_i       (run_i),
    .run_base_i  (run_base_i),
    .run_len_i   (run_len_i),
    .run_busy_o  (run_busy_o),
    .coef_full_i (coef_full_i),
    .coef_o      (coef_o),
    .coef_vld_o  (coef_vld_o)
  );

  always #5 clk = ~clk;

  // Collect every coefficient the pipeline emits
  always @(negedge clk) begin
    if (rst_n && coef_vld_o) begin
      got_q.push_back(coef_o);
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name);
    int n_errs;
    n_errs = err_cnt - err_base;
    $display("Test %0d (%s): %0d mismatches", test_idx, name, n_errs);
    if (n_errs == 0) begin
      pass_cnt++;
    end else begin
      fail_cnt++;
    end
    err_base = err_cnt;
    test_idx++;
  endtask

  // ==================================================
  // Stimulus
  // ==================================================
  task automatic write_weight(input logic [63:0] cmd);
    @(posedge clk);
    a_wr_i   <= 1'b1;
    a_idx_i  <= cmd[54:52];
    a_data_i <= cmd[7:0];
    @(posedge clk);
    a_wr_i <= 1'b0;
  endtask

  task automatic write_row(input logic [63:0] cmd);
    int gap;
    // Short random gaps so writes collide with fetch reads
    gap = {$random(seed)} % 2;
    repeat (gap) @(posedge clk);
    @(posedge clk);
    wh_wr_i   <= 1'b1;
    wh_addr_i <= cmd[56:52];
    wh_data_i <= cmd[48:0];
    @(posedge clk);
    wh_wr_i <= 1'b0;
    @(negedge clk);
    while (wh_busy_o) begin
      @(negedge clk);
    end
  endtask

  task automatic start_run(input logic [63:0] cmd);
    @(posedge clk);
    run_i      <= 1'b1;
    run_base_i <= cmd[56:52];
    run_len_i  <= cmd[5:0];
    @(posedge clk);
    run_i <= 1'b0;
  endtask

  // One pattern bit per cycle, LSB first
  task automatic drive_full(input logic [63:0] cmd);
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      coef_full_i <= cmd[i];
    end
    @(posedge clk);
    coef_full_i <= 1'b0;
  endtask

  task automatic finish_test();
    @(negedge clk);
    while (run_busy_o) begin
      @(negedge clk);
    end
    // Rows in flight drain within the fixed pipeline latency
    repeat (gat_coef_pkg::DMVM_LATENCY + 2) @(negedge clk);
    check_value("coef count", got_q.size(), exp_q.size());
    for (int i = 0; i < exp_q.size(); i++) begin
      if (i < got_q.size()) begin
        check_value($sformatf("coef_o[%0d]", i), got_q[i], exp_q[i]);
      end
    end
    report_test("run");
    got_q.delete();
    exp_q.delete();
  endtask

  task automatic check_idle();
    repeat (IDLE_CYCLES) begin
      @(negedge clk);
      check_value("coef_vld_o", coef_vld_o, 0);
      check_value("wh_busy_o", wh_busy_o, 0);
      check_value("run_busy_o", run_busy_o, 0);
    end
    report_test("idle");
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    wh_wr_i     = 1'b0;
    wh_addr_i   = '0;
    wh_data_i   = '0;
    a_wr_i      = 1'b0;
    a_idx_i     = '0;
    a_data_i    = '0;
    run_i       = 1'b0;
    run_base_i  = '0;
    run_len_i   = '0;
    coef_full_i = 1'b0;
    seed        = 32'hd388;
    err_cnt     = 0;
    err_base    = 0;
    test_idx    = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    for (int i = 0; i < MAX_CMDS; i++) begin
      cmd_mem[i] = '0;
    end
    $readmemh("verification/coef_golden.txt", cmd_mem);
    while (num_cmds < MAX_CMDS && cmd_mem[num_cmds][63:60] != 4'h0) begin
      num_cmds++;
    end
    if (num_cmds == 0) begin
      $display("Golden file is missing or holds no commands");
      err_cnt++;
    end
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    check_idle();
    for (int i = 0; i < num_cmds; i++) begin
      case (cmd_mem[i][63:60])
        OP_WEIGHT: write_weight(cmd_mem[i]);
        OP_ROW:    write_row(cmd_mem[i]);
        OP_RUN:    start_run(cmd_mem[i]);
        OP_FULL:   drive_full(cmd_mem[i]);
        OP_EXPECT: exp_q.push_back(cmd_mem[i][7:0]);
        OP_END:    finish_test();
        default: begin
          $display("Unknown opcode %0h on golden entry %0d", cmd_mem[i][63:60], i);
          err_cnt++;
        end
      endcase
    end
    $display("Summary: %0d tests clean, %0d with errors, %0d mismatches, %0d assert fails",
             pass_cnt, fail_cnt, err_cnt, DUT.u_asserts.assert_errs);
    if (fail_cnt == 0 && err_cnt == 0 && DUT.u_asserts.assert_errs == 0 && pass_cnt > 1) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog sized from the golden file length
  initial begin
    wait (num_cmds > 0);
    repeat (CYCLES_PER_LINE * num_cmds + RST_CYCLES + IDLE_CYCLES) @(posedge clk);
    $display("Timeout: the run did not complete within %0d cycles",
             CYCLES_PER_LINE * num_cmds + RST_CYCLES + IDLE_CYCLES);
    $display("test failed");
    $finish;
  end

endmodule
